// File: rvExec_defines.svh
`ifndef RVEXEC_DEFINES_SVH
`define RVEXEC_DEFINES_SVH

// Datapath width of the integer core
`define RV_XLEN 32

// Program counter width
`define RV_PC_WIDTH 32

// Register file address width for x0..x31
`define RV_REG_AW 5

`endif

// File: rvExecPkg.sv
`default_nettype none

`include "rvExec_defines.svh"

package rvExecPkg;

    // ALU operation codes as decoded in ID
    typedef enum logic [4:0] {
        ALU_ADD   = 5'd0,
        ALU_SUB   = 5'd1,
        ALU_SLL   = 5'd2,
        ALU_SLT   = 5'd3,
        ALU_SLTU  = 5'd4,
        ALU_XOR   = 5'd5,
        ALU_SRL   = 5'd6,
        ALU_SRA   = 5'd7,
        ALU_OR    = 5'd8,
        ALU_AND   = 5'd9,
        ALU_PASSB = 5'd10                          // Used by LUI
    } aluOp_t;

    // Write-back source select
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wbSel_t;

    typedef struct packed {
        logic [2:0]              dbgTag;        // Debug tag
        logic [`RV_PC_WIDTH-1:0] pc;
        logic [6:0]              instOp;        // Instruction opcode
        logic [`RV_REG_AW-1:0]   rs1;
        logic [`RV_REG_AW-1:0]   rs2;
        logic [`RV_XLEN-1:0]     imm;           // Sign-extended immediate
        logic [`RV_XLEN-1:0]     dataA;         // rs1 value read in decode
        logic [`RV_XLEN-1:0]     dataB;         // rs2 value read in decode
        logic [`RV_REG_AW-1:0]   regWrAddr;
        logic                    regWrEnable;
        wbSel_t                  regWrDataSel;
        logic                    memWrEnable;
        logic                    operandASel;   // 1 selects PC
        logic                    operandBSel;   // 1 selects immediate
        aluOp_t                  aluControl;
    } idExPayload_t;

    typedef struct packed {
        logic [2:0]              dbgTag;
        logic [`RV_PC_WIDTH-1:0] pc;
        logic [`RV_XLEN-1:0]     aluResult;
        logic [`RV_XLEN-1:0]     storeData;     // Forwarded rs2 for stores
        logic [`RV_REG_AW-1:0]   regWrAddr;
        logic                    regWrEnable;
        wbSel_t                  regWrDataSel;
        logic                    memWrEnable;
    } exMemPayload_t;

endpackage

`default_nettype wire

// File: pipelineReg.sv
`default_nettype none
`timescale 1ns/1ps

module pipelineReg #(
    parameter type payload_t = logic
) (
    input  logic     i_Clock,
    input  logic     i_reset,
    input  logic     i_Stall,                      // Hold current contents
    input  logic     i_Flush,                      // Load a bubble
    input  payload_t i_Data,
    output payload_t o_Data
);

    // Priority encoding of the control levels
    localparam logic [2:0] CTRL_RESET = 3'b1??;
    localparam logic [2:0] CTRL_STALL = 3'b01?;
    localparam logic [2:0] CTRL_FLUSH = 3'b001;

    logic [2:0] ctrlCode;

    assign ctrlCode = {i_reset, i_Stall, i_Flush};

    always_ff @(posedge i_Clock) begin
        casez (ctrlCode)
            CTRL_RESET: begin
                o_Data <= '0;                      // Bubble
            end
            CTRL_STALL: begin
                o_Data <= o_Data;
            end
            CTRL_FLUSH: begin
                o_Data <= '0;                      // Bubble
            end
            default: begin
                o_Data <= i_Data;
            end
        endcase
    end

    // Stall freezes the stage for the following cycle
    aHoldOnStall: assert property (
        @(posedge i_Clock) (!i_reset && i_Stall) |=> (o_Data == $past(o_Data))
    ) else $error("pipelineReg changed while stalled");

    // Reset, or a flush that is not stalled, leaves a bubble behind
    aBubbleAfterClear: assert property (
        @(posedge i_Clock) (i_reset || (i_Flush && !i_Stall)) |=> (o_Data == '0)
    ) else $error("pipelineReg not cleared after reset or flush");

endmodule

`default_nettype wire

// File: operandForward.sv
`default_nettype none
`timescale 1ns/1ps

`include "rvExec_defines.svh"

module operandForward (
    input  logic [`RV_REG_AW-1:0] i_Rs1,
    input  logic [`RV_REG_AW-1:0] i_Rs2,
    input  logic [`RV_XLEN-1:0]   i_RegDataA,       // Value read in decode
    input  logic [`RV_XLEN-1:0]   i_RegDataB,
    input  rvExecPkg::exMemPayload_t i_ExMem,      // Output of the EX/MEM register
    output logic [`RV_XLEN-1:0]   o_DataA,
    output logic [`RV_XLEN-1:0]   o_DataB
);

    import rvExecPkg::*;

    logic exMemWritesAlu;
    logic fwdA;
    logic fwdB;

    // Only ALU results exist at this point, loads come later
    assign exMemWritesAlu = i_ExMem.regWrEnable
                         && (i_ExMem.regWrDataSel == WB_ALU)
                         && (i_ExMem.regWrAddr != '0);

    assign fwdA = exMemWritesAlu && (i_ExMem.regWrAddr == i_Rs1);
    assign fwdB = exMemWritesAlu && (i_ExMem.regWrAddr == i_Rs2);

    assign o_DataA = fwdA ? i_ExMem.aluResult : i_RegDataA;
    assign o_DataB = fwdB ? i_ExMem.aluResult : i_RegDataB;

    // An x0 operand always keeps the decode value
    always_comb begin
        assert ((i_Rs1 != '0) || (o_DataA == i_RegDataA))
            else $error("operandForward forwarded into x0 on operand A");
        assert ((i_Rs2 != '0) || (o_DataB == i_RegDataB))
            else $error("operandForward forwarded into x0 on operand B");
    end

endmodule

`default_nettype wire

// File: aluUnit.sv
`default_nettype none
`timescale 1ns/1ps

`include "rvExec_defines.svh"

module aluUnit (
    input  logic [`RV_XLEN-1:0] i_RegA,            // Forwarded rs1
    input  logic [`RV_XLEN-1:0] i_RegB,            // Forwarded rs2
    input  logic [`RV_XLEN-1:0] i_Pc,
    input  logic [`RV_XLEN-1:0] i_Imm,
    input  logic                i_OperandASel,     // 1 selects PC
    input  logic                i_OperandBSel,     // 1 selects immediate
    input  rvExecPkg::aluOp_t   i_AluOp,
    output logic [`RV_XLEN-1:0] o_Result
);

    import rvExecPkg::*;

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0] opA;
    logic [`RV_XLEN-1:0] opB;
    logic [SHAMT_W-1:0]  shamt;

    assign opA   = i_OperandASel ? i_Pc  : i_RegA;
    assign opB   = i_OperandBSel ? i_Imm : i_RegB;
    assign shamt = opB[SHAMT_W-1:0];               // Low bits of B only

    always_comb begin
        case (i_AluOp)
            ALU_ADD: begin
                o_Result = opA + opB;
            end
            ALU_SUB: begin
                o_Result = opA - opB;
            end
            ALU_SLL: begin
                o_Result = opA << shamt;
            end
            ALU_SLT: begin
                o_Result = {{(`RV_XLEN-1){1'b0}}, ($signed(opA) < $signed(opB))};
            end
            ALU_SLTU: begin
                o_Result = {{(`RV_XLEN-1){1'b0}}, (opA < opB)};
            end
            ALU_XOR: begin
                o_Result = opA ^ opB;
            end
            ALU_SRL: begin
                o_Result = opA >> shamt;
            end
            ALU_SRA: begin
                o_Result = $unsigned($signed(opA) >>> shamt);  // Sign fill
            end
            ALU_OR: begin
                o_Result = opA | opB;
            end
            ALU_AND: begin
                o_Result = opA & opB;
            end
            ALU_PASSB: begin
                o_Result = opB;                    // LUI path
            end
            default: begin
                o_Result = '0;
            end
        endcase
    end

    // Decode must never hand over an unassigned opcode
    always_comb begin
        assert ($isunknown(i_AluOp) || (i_AluOp <= ALU_PASSB))
            else $error("aluUnit received undefined operation %0d", i_AluOp);
    end

endmodule

`default_nettype wire

// File: execStage.sv
`default_nettype none
`timescale 1ns/1ps

`include "rvExec_defines.svh"

module execStage (
    input  logic                     i_Clock,
    input  logic                     i_reset,
    input  logic                     i_Stall,      // Freezes both registers
    input  logic                     i_Flush,      // Bubbles the ID/EX register
    input  rvExecPkg::idExPayload_t  i_IdEx,
    output rvExecPkg::exMemPayload_t o_ExMem
);

    import rvExecPkg::*;

    idExPayload_t        idEx;
    exMemPayload_t       exNext;
    logic [`RV_XLEN-1:0] fwdDataA;
    logic [`RV_XLEN-1:0] fwdDataB;
    logic [`RV_XLEN-1:0] aluResult;

    pipelineReg #(.payload_t(idExPayload_t)) uIdExReg (
        .i_Clock (i_Clock),
        .i_reset (i_reset),
        .i_Stall (i_Stall),
        .i_Flush (i_Flush),
        .i_Data  (i_IdEx),
        .o_Data  (idEx)
    );

    operandForward uForward (
        .i_Rs1      (idEx.rs1),
        .i_Rs2      (idEx.rs2),
        .i_RegDataA (idEx.dataA),
        .i_RegDataB (idEx.dataB),
        .i_ExMem    (o_ExMem),                     // Result one stage ahead
        .o_DataA    (fwdDataA),
        .o_DataB    (fwdDataB)
    );

    aluUnit uAlu (
        .i_RegA        (fwdDataA),
        .i_RegB        (fwdDataB),
        .i_Pc          (idEx.pc),
        .i_Imm         (idEx.imm),
        .i_OperandASel (idEx.operandASel),
        .i_OperandBSel (idEx.operandBSel),
        .i_AluOp       (idEx.aluControl),
        .o_Result      (aluResult)
    );

    always_comb begin
        exNext              = '0;
        exNext.dbgTag       = idEx.dbgTag;
        exNext.pc           = idEx.pc;
        exNext.aluResult    = aluResult;
        exNext.storeData    = fwdDataB;            // Store data sees forwarding too
        exNext.regWrAddr    = idEx.regWrAddr;
        exNext.regWrEnable  = idEx.regWrEnable;
        exNext.regWrDataSel = idEx.regWrDataSel;
        exNext.memWrEnable  = idEx.memWrEnable;
    end

    pipelineReg #(.payload_t(exMemPayload_t)) uExMemReg (
        .i_Clock (i_Clock),
        .i_reset (i_reset),
        .i_Stall (i_Stall),
        .i_Flush (1'b0),                           // Never flushed here
        .i_Data  (exNext),
        .o_Data  (o_ExMem)
    );

endmodule

`default_nettype wire

// File: tbExecStage.sv
`default_nettype none
`timescale 1ns/1ps

`include "rvExec_defines.svh"

module tbExecStage;

    import rvExecPkg::*;

    localparam int DRAIN_LIMIT = 200;                        // Cycles allowed to empty the stage
    localparam logic [`RV_PC_WIDTH-1:0] PC_BASE = 32'h0000_0100;

    typedef struct packed {
        aluOp_t                op;
        logic [`RV_XLEN-1:0]   dataA;
        logic [`RV_XLEN-1:0]   dataB;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic [1:0]            sel;                          // {PC for A, imm for B}
        logic                  wrEn;
        wbSel_t                wbSel;
        logic                  memWr;
        logic                  stall;
        logic                  flush;
        logic [`RV_XLEN-1:0]   expResult;                    // aluResult when the item leaves
    } stimRow_t;

    logic          clock;
    logic          reset;
    logic          stall;
    logic          flush;
    idExPayload_t  idExIn;
    exMemPayload_t exMemOut;

    idExPayload_t  modelIdEx;
    exMemPayload_t modelExMem;
    exMemPayload_t fillAhead;                                // Item ahead while building rows
    stimRow_t      stimTable[$];
    integer        seed = 32'h34c0ebdc;
    int            errorCount = 0;
    int            checkCount = 0;
    int            seenCount = 0;
    int            expectedCount = 0;
    int            waitCycles;
    int            rowIdx;
    logic          checkOn = 1'b0;
    logic [`RV_PC_WIDTH-1:0] lastPc = '0;

    execStage i_execStage (
        .i_Clock (clock),
        .i_reset (reset),
        .i_Stall (stall),
        .i_Flush (flush),
        .i_IdEx  (idExIn),
        .o_ExMem (exMemOut)
    );

    always #4 clock = ~clock;

    function automatic logic [`RV_XLEN-1:0] aluRef(aluOp_t op, logic [`RV_XLEN-1:0] a,
                                                   logic [`RV_XLEN-1:0] b);
        case (op)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_SLL:   return a << b[4:0];
            ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:   return a ^ b;
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA:   return $signed(a) >>> b[4:0];
            ALU_OR:    return a | b;
            ALU_AND:   return a & b;
            ALU_PASSB: return b;
            default:   return '0;
        endcase
    endfunction

    // Only an ALU write to a real register one stage ahead is forwarded
    function automatic logic [`RV_XLEN-1:0] forwardValue(exMemPayload_t ahead,
            logic [`RV_REG_AW-1:0] rs, logic [`RV_XLEN-1:0] regVal);
        if (ahead.regWrEnable && ahead.regWrDataSel == WB_ALU && ahead.regWrAddr != '0
                && ahead.regWrAddr == rs)
            return ahead.aluResult;
        return regVal;
    endfunction

    function automatic exMemPayload_t modelExecute(idExPayload_t item, exMemPayload_t ahead);
        exMemPayload_t       out;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        a = forwardValue(ahead, item.rs1, item.dataA);
        b = forwardValue(ahead, item.rs2, item.dataB);
        out = '0;
        out.dbgTag = item.dbgTag;
        out.pc = item.pc;
        out.aluResult = aluRef(item.aluControl, item.operandASel ? item.pc : a,
                               item.operandBSel ? item.imm : b);
        out.storeData = b;
        out.regWrAddr = item.regWrAddr;
        out.regWrEnable = item.regWrEnable;
        out.regWrDataSel = item.regWrDataSel;
        out.memWrEnable = item.memWrEnable;
        return out;
    endfunction

    function automatic idExPayload_t rowPayload(stimRow_t row, int idx);
        idExPayload_t p;
        p = '0;
        p.dbgTag = 3'(idx);
        p.pc = PC_BASE + 32'(idx * 4);                       // Row index recoverable from pc
        p.instOp = row.sel[0] ? 7'h13 : 7'h33;               // OP-IMM or OP
        p.rs1 = row.rs1;
        p.rs2 = row.rs2;
        p.imm = row.imm;
        p.dataA = row.dataA;
        p.dataB = row.dataB;
        p.regWrAddr = row.rd;
        p.regWrEnable = row.wrEn;
        p.regWrDataSel = row.wbSel;
        p.memWrEnable = row.memWr;
        p.operandASel = row.sel[1];
        p.operandBSel = row.sel[0];
        p.aluControl = row.op;
        return p;
    endfunction

    task automatic addRow(aluOp_t op, logic [`RV_REG_AW-1:0] rs1, logic [`RV_REG_AW-1:0] rs2,
                          logic [`RV_REG_AW-1:0] rd, logic [1:0] sel, logic wrEn,
                          wbSel_t wbSel, logic memWr, logic stallRow, logic flushRow);
        stimRow_t      row;
        exMemPayload_t out;
        row.op = op;
        row.dataA = $random(seed);
        row.dataB = $random(seed);
        row.imm = $random(seed);
        row.rs1 = rs1;
        row.rs2 = rs2;
        row.rd = rd;
        row.sel = sel;
        row.wrEn = wrEn;
        row.wbSel = wbSel;
        row.memWr = memWr;
        row.stall = stallRow;
        row.flush = flushRow;
        row.expResult = '0;
        if (flushRow) begin
            fillAhead = '0;                                  // Bubble follows the item ahead
        end else if (!stallRow) begin
            out = modelExecute(rowPayload(row, stimTable.size()), fillAhead);
            row.expResult = out.aluResult;
            fillAhead = out;
            expectedCount++;
        end
        stimTable.push_back(row);
    endtask

    task automatic buildTable();
        for (int op = 0; op <= 10; op++) begin
            for (int sel = 0; sel < 4; sel++) begin
                addRow(aluOp_t'(5'(op)), 5'd10, 5'd11, 5'd20, 2'(sel),
                       1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);
            end
        end
        addRow(ALU_ADD, 5'd1, 5'd2, 5'd5, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);
        addRow(ALU_ADD, 5'd5, 5'd5, 5'd6, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);   // Both forward
        addRow(ALU_XOR, 5'd6, 5'd3, 5'd0, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);   // Writes x0
        addRow(ALU_AND, 5'd0, 5'd0, 5'd7, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);
        addRow(ALU_ADD, 5'd1, 5'd2, 5'd8, 2'b01, 1'b1, WB_MEM, 1'b0, 1'b0, 1'b0);   // Load
        addRow(ALU_OR, 5'd8, 5'd8, 5'd9, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);
        addRow(ALU_ADD, 5'd3, 5'd4, 5'd10, 2'b00, 1'b0, WB_ALU, 1'b0, 1'b0, 1'b0);  // No write
        addRow(ALU_SLT, 5'd10, 5'd10, 5'd11, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);
        // Three stalled cycles with a dependency held across them
        addRow(ALU_ADD, 5'd1, 5'd2, 5'd12, 2'b01, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);
        addRow(ALU_SUB, 5'd12, 5'd3, 5'd13, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);
        repeat (3) addRow(ALU_ADD, 5'd1, 5'd2, 5'd3, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b1, 1'b0);
        addRow(ALU_OR, 5'd13, 5'd12, 5'd14, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);
        addRow(ALU_XOR, 5'd1, 5'd2, 5'd15, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);
        addRow(ALU_ADD, 5'd15, 5'd15, 5'd16, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b1); // Flushed
        addRow(ALU_AND, 5'd15, 5'd16, 5'd17, 2'b00, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);
        addRow(ALU_ADD, 5'd1, 5'd2, 5'd18, 2'b01, 1'b1, WB_ALU, 1'b0, 1'b0, 1'b0);
        addRow(ALU_ADD, 5'd3, 5'd18, 5'd0, 2'b01, 1'b0, WB_ALU, 1'b1, 1'b0, 1'b0);  // Store
        addRow(ALU_PASSB, 5'd0, 5'd0, 5'd19, 2'b11, 1'b1, WB_PC4, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic checkField(string name, logic [`RV_XLEN-1:0] got,
                              logic [`RV_XLEN-1:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Model of both registers with reset > stall > flush > load
    always @(posedge clock) begin
        if (reset) begin
            modelIdEx <= '0;
            modelExMem <= '0;
        end else if (!stall) begin
            modelExMem <= modelExecute(modelIdEx, modelExMem);
            if (flush) begin
                modelIdEx <= '0;
            end else begin
                modelIdEx <= idExIn;
            end
        end
    end

    always @(negedge clock) begin
        if (checkOn) begin
            checkField("dbgTag", 32'(exMemOut.dbgTag), 32'(modelExMem.dbgTag));
            checkField("pc", exMemOut.pc, modelExMem.pc);
            checkField("aluResult", exMemOut.aluResult, modelExMem.aluResult);
            checkField("storeData", exMemOut.storeData, modelExMem.storeData);
            checkField("regWrAddr", 32'(exMemOut.regWrAddr), 32'(modelExMem.regWrAddr));
            checkField("regWrEnable", 32'(exMemOut.regWrEnable), 32'(modelExMem.regWrEnable));
            checkField("regWrDataSel", 32'(exMemOut.regWrDataSel),
                       32'(modelExMem.regWrDataSel));
            checkField("memWrEnable", 32'(exMemOut.memWrEnable), 32'(modelExMem.memWrEnable));
            if (exMemOut.pc != '0 && exMemOut.pc != lastPc) begin
                rowIdx = int'((exMemOut.pc - PC_BASE) >> 2);
                seenCount++;
                if (rowIdx < stimTable.size()) begin
                    checkField("aluResult from table", exMemOut.aluResult,
                               stimTable[rowIdx].expResult);
                end else begin
                    errorCount++;
                    $display("Unexpected item with pc %h left the stage", exMemOut.pc);
                end
            end
            lastPc = exMemOut.pc;
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        idExIn = '0;
        fillAhead = '0;
        buildTable();
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        checkField("o_ExMem after reset", 32'(exMemOut != '0), 32'd0);
        checkField("regWrEnable after reset", 32'(exMemOut.regWrEnable), 32'd0);
        checkField("memWrEnable after reset", 32'(exMemOut.memWrEnable), 32'd0);
        checkOn <= 1'b1;
        foreach (stimTable[r]) begin
            @(posedge clock);
            stall <= stimTable[r].stall;
            flush <= stimTable[r].flush;
            idExIn <= rowPayload(stimTable[r], r);
        end
        @(posedge clock);
        stall <= 1'b0;
        flush <= 1'b0;
        idExIn <= '0;                                        // Idle bubbles while draining
        waitCycles = 0;
        while (seenCount < expectedCount && waitCycles < DRAIN_LIMIT) begin
            @(posedge clock);
            waitCycles++;
        end
        if (seenCount < expectedCount) begin
            errorCount++;
            $display("Timeout: only %0d of %0d items left the stage", seenCount, expectedCount);
        end
        @(posedge clock);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
rvExecPkg.sv
pipelineReg.sv
operandForward.sv
aluUnit.sv
execStage.sv
tbExecStage.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build the execute-stage testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log \
    && verilator --binary --timing --assert -Wno-fatal \
        --top-module tbExecStage -f src.f -o simExecStage \
    && ./obj_dir/simExecStage 2>&1 | tee sim.log \
    && grep -q "^Test OK$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
